//--- common/csr_pkg.sv
package csr_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // commands carried from decode to the CSR file
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef enum logic [2:0] {
        CSR_NONE  = 3'd0,  // no operation, never valid past decode
        CSR_WRITE = 3'd1,  // CSRRW and CSRRWI
        CSR_SET   = 3'd2,  // CSRRS and CSRRSI
        CSR_CLEAR = 3'd3,  // CSRRC and CSRRCI
        CSR_ECALL = 3'd4   // environment call from machine mode
    } csr_cmd_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // machine CSR addresses
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam logic [11:0] CSR_MSTATUS  = 12'h300;
    localparam logic [11:0] CSR_MTVEC    = 12'h305;
    localparam logic [11:0] CSR_MSCRATCH = 12'h340;
    localparam logic [11:0] CSR_MEPC     = 12'h341;
    localparam logic [11:0] CSR_MCAUSE   = 12'h342;
    localparam logic [11:0] CSR_MHARTID  = 12'hF14;  // read-only, reads as zero

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // field masks and fixed values
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // only MIE (bit 3) and MPIE (bit 7) are implemented in mstatus
    localparam logic [31:0] MSTATUS_WMASK = 32'h0000_0088;

    localparam logic [31:0] CAUSE_ECALL_M = 32'd11;  // environment call from M-mode

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instruction encoding
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam logic [6:0] OPC_SYSTEM = 7'b111_0011;

    localparam logic [2:0] F3_PRIV   = 3'b000;  // ECALL, EBREAK, MRET, WFI share this
    localparam logic [2:0] F3_CSRRW  = 3'b001;
    localparam logic [2:0] F3_CSRRS  = 3'b010;
    localparam logic [2:0] F3_CSRRC  = 3'b011;
    localparam logic [2:0] F3_CSRRWI = 3'b101;
    localparam logic [2:0] F3_CSRRSI = 3'b110;
    localparam logic [2:0] F3_CSRRCI = 3'b111;

    // ECALL is the one fully fixed encoding, all other fields zero
    localparam logic [31:0] INSTR_ECALL = 32'h0000_0073;

endpackage

//--- rtl/csr_decode.sv
`timescale 1ns/10ps

module csr_decode
    import csr_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    input  logic        instr_valid,
    input  logic [31:0] instr,
    input  logic [31:0] rs1_data,
    input  logic [31:0] pc,
    input  logic        flush,

    output logic        dec_valid,
    output csr_cmd_e    dec_cmd,
    output logic [11:0] dec_addr,
    output logic [31:0] dec_operand,
    output logic [4:0]  dec_rd,
    output logic [31:0] dec_pc,
    output logic        dec_write
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // instruction fields
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic [6:0]  opcode;
    logic [2:0]  funct3;
    logic [4:0]  rs1_field;
    logic [4:0]  rd_field;
    logic [11:0] csr_field;
    logic [31:0] uimm;

    assign opcode    = instr[6:0];
    assign rd_field  = instr[11:7];
    assign funct3    = instr[14:12];
    assign rs1_field = instr[19:15];  // register index or 5-bit immediate
    assign csr_field = instr[31:20];
    assign uimm      = {27'd0, rs1_field};

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // command decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    csr_cmd_e    cmd_c;
    logic [11:0] addr_c;
    logic [31:0] operand_c;
    logic        write_c;
    logic        accept;

    always_comb begin
        cmd_c     = CSR_NONE;
        addr_c    = csr_field;
        operand_c = rs1_data;
        write_c   = 1'b0;
        if (opcode == OPC_SYSTEM) begin
            case (funct3)
                F3_CSRRW: begin
                    cmd_c   = CSR_WRITE;
                    write_c = 1'b1;
                end
                F3_CSRRS: begin
                    cmd_c   = CSR_SET;
                    write_c = (rs1_field != 5'd0);  // rs1 of x0 means read only
                end
                F3_CSRRC: begin
                    cmd_c   = CSR_CLEAR;
                    write_c = (rs1_field != 5'd0);
                end
                F3_CSRRWI: begin
                    cmd_c     = CSR_WRITE;
                    operand_c = uimm;
                    write_c   = 1'b1;
                end
                F3_CSRRSI: begin
                    cmd_c     = CSR_SET;
                    operand_c = uimm;
                    write_c   = (rs1_field != 5'd0);  // zero immediate also only reads
                end
                F3_CSRRCI: begin
                    cmd_c     = CSR_CLEAR;
                    operand_c = uimm;
                    write_c   = (rs1_field != 5'd0);
                end
                F3_PRIV: begin
                    if (instr == INSTR_ECALL) begin
                        cmd_c  = CSR_ECALL;
                        addr_c = CSR_MCAUSE;  // the trap reports mcause as its read address
                    end
                end
                default: begin
                    cmd_c = CSR_NONE;  // reserved funct3 drops out here
                end
            endcase
        end
    end

    assign accept = instr_valid && !flush && (cmd_c != CSR_NONE);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid) begin
            dec_cmd     <= cmd_c;
            dec_addr    <= addr_c;
            dec_operand <= operand_c;
            dec_rd      <= rd_field;
            dec_pc      <= pc;
            dec_write   <= write_c;
        end
    end

    // the stage register must never carry an empty command forward
    a_dec_cmd_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        dec_valid |-> (dec_cmd != CSR_NONE)
    );

endmodule

//--- csr_file/csr_file.sv
`timescale 1ns/10ps

module csr_file
    import csr_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    input  logic        dec_valid,
    input  csr_cmd_e    dec_cmd,
    input  logic [11:0] dec_addr,
    input  logic [31:0] dec_operand,
    input  logic [31:0] dec_pc,
    input  logic        dec_write,

    output logic [31:0] file_rdata,
    output logic        file_illegal,
    output logic        file_trap,
    output logic [31:0] mtvec_q
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic [31:0] mstatus_q;
    logic [31:0] mscratch_q;
    logic [31:0] mepc_q;
    logic [31:0] mcause_q;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read side and legality
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic [31:0] rdata;
    logic        addr_hit;
    logic        addr_ro;
    logic        is_ecall;

    always_comb begin
        addr_hit = 1'b1;
        case (dec_addr)
            CSR_MSTATUS:  rdata = mstatus_q;
            CSR_MTVEC:    rdata = mtvec_q;
            CSR_MSCRATCH: rdata = mscratch_q;
            CSR_MEPC:     rdata = mepc_q;
            CSR_MCAUSE:   rdata = mcause_q;
            CSR_MHARTID:  rdata = 32'd0;  // single hart
            default: begin
                rdata    = 32'd0;
                addr_hit = 1'b0;
            end
        endcase
    end

    assign addr_ro  = &dec_addr[11:10];  // top two address bits both set marks read-only space
    assign is_ecall = (dec_cmd == CSR_ECALL);

    assign file_rdata   = rdata;
    assign file_trap    = dec_valid && is_ecall;
    assign file_illegal = dec_valid && !is_ecall && (!addr_hit || (dec_write && addr_ro));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // read-modify-write
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic [31:0] wdata;
    logic        do_write;

    always_comb begin
        case (dec_cmd)
            CSR_WRITE: wdata = dec_operand;
            CSR_SET:   wdata = rdata | dec_operand;
            CSR_CLEAR: wdata = rdata & ~dec_operand;
            default:   wdata = rdata;
        endcase
    end

    assign do_write = dec_valid && dec_write && !is_ecall && !file_illegal;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mstatus_q  <= 32'd0;
            mtvec_q    <= 32'd0;
            mscratch_q <= 32'd0;
            mepc_q     <= 32'd0;
            mcause_q   <= 32'd0;
        end else if (file_trap) begin
            mepc_q   <= dec_pc;         // address of the ECALL itself
            mcause_q <= CAUSE_ECALL_M;
        end else if (do_write) begin
            case (dec_addr)
                CSR_MSTATUS:  mstatus_q  <= wdata & MSTATUS_WMASK;
                CSR_MTVEC:    mtvec_q    <= {wdata[31:2], 2'b00};  // direct mode only
                CSR_MSCRATCH: mscratch_q <= wdata;
                CSR_MEPC:     mepc_q     <= {wdata[31:2], 2'b00};
                CSR_MCAUSE:   mcause_q   <= wdata;
                default: begin
                    mstatus_q <= mstatus_q;  // mhartid writes never get here
                end
            endcase
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // checks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    a_illegal_not_trap: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(file_illegal && file_trap)
    );

    // a rejected access must leave every register as it was across its write edge
    a_illegal_no_change: assert property (
        @(posedge clk) disable iff (!rst_n)
        file_illegal |=> $stable({mstatus_q, mtvec_q, mscratch_q, mepc_q, mcause_q})
    );

endmodule

//--- rtl/csr_writeback.sv
`timescale 1ns/10ps

module csr_writeback (
    input  logic        clk,
    input  logic        rst_n,

    input  logic        dec_valid,
    input  logic [4:0]  dec_rd,
    input  logic [31:0] file_rdata,
    input  logic        file_illegal,
    input  logic        file_trap,
    input  logic [31:0] mtvec_q,

    output logic        rd_valid,
    output logic [4:0]  rd_addr,
    output logic [31:0] rd_data,
    output logic        illegal,
    output logic        trap_taken,
    output logic [31:0] trap_vector
);

    logic no_result;

    assign no_result = file_illegal || file_trap;  // neither returns a CSR value

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // control flags
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid   <= 1'b0;
            illegal    <= 1'b0;
            trap_taken <= 1'b0;
        end else begin
            rd_valid   <= dec_valid;
            illegal    <= dec_valid && file_illegal;
            trap_taken <= dec_valid && file_trap;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // result payload
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        rd_addr     <= dec_rd;
        rd_data     <= no_result ? 32'd0 : file_rdata;
        trap_vector <= mtvec_q;  // follows mtvec every cycle, valid alongside trap_taken
    end

endmodule

//--- rtl/csr_unit.sv
`timescale 1ns/10ps

module csr_unit
    import csr_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    input  logic        instr_valid,
    input  logic [31:0] instr,
    input  logic [31:0] rs1_data,
    input  logic [31:0] pc,
    input  logic        flush,

    output logic        rd_valid,
    output logic [4:0]  rd_addr,
    output logic [31:0] rd_data,
    output logic        illegal,
    output logic        trap_taken,
    output logic [31:0] trap_vector
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // decode stage register
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    logic        dec_valid;
    csr_cmd_e    dec_cmd;
    logic [11:0] dec_addr;
    logic [31:0] dec_operand;
    logic [4:0]  dec_rd;
    logic [31:0] dec_pc;
    logic        dec_write;

    // CSR file results, combinational from the stage register
    logic [31:0] file_rdata;
    logic        file_illegal;
    logic        file_trap;
    logic [31:0] mtvec_q;

    csr_decode u_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .rs1_data    (rs1_data),
        .pc          (pc),
        .flush       (flush),
        .dec_valid   (dec_valid),
        .dec_cmd     (dec_cmd),
        .dec_addr    (dec_addr),
        .dec_operand (dec_operand),
        .dec_rd      (dec_rd),
        .dec_pc      (dec_pc),
        .dec_write   (dec_write)
    );

    csr_file u_file (
        .clk          (clk),
        .rst_n        (rst_n),
        .dec_valid    (dec_valid),
        .dec_cmd      (dec_cmd),
        .dec_addr     (dec_addr),
        .dec_operand  (dec_operand),
        .dec_pc       (dec_pc),
        .dec_write    (dec_write),
        .file_rdata   (file_rdata),
        .file_illegal (file_illegal),
        .file_trap    (file_trap),
        .mtvec_q      (mtvec_q)
    );

    csr_writeback u_writeback (
        .clk          (clk),
        .rst_n        (rst_n),
        .dec_valid    (dec_valid),
        .dec_rd       (dec_rd),
        .file_rdata   (file_rdata),
        .file_illegal (file_illegal),
        .file_trap    (file_trap),
        .mtvec_q      (mtvec_q),
        .rd_valid     (rd_valid),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data),
        .illegal      (illegal),
        .trap_taken   (trap_taken),
        .trap_vector  (trap_vector)
    );

endmodule

//--- verif/csr_model.svh
`ifndef CSR_MODEL_SVH
`define CSR_MODEL_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// reference state and instruction encoder
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

logic [31:0] m_mstatus;
logic [31:0] m_mtvec;
logic [31:0] m_mscratch;
logic [31:0] m_mepc;
logic [31:0] m_mcause;

function automatic logic [31:0] csr_instr(input logic [2:0] f3, input logic [11:0] addr,
                                          input logic [4:0] src, input logic [4:0] rd);
    return {addr, src, f3, rd, OPC_SYSTEM};
endfunction

function automatic logic [31:0] ecall_instr();
    return {12'd0, 5'd0, F3_PRIV, 5'd0, OPC_SYSTEM};
endfunction

function automatic logic csr_known(input logic [11:0] addr);
    return (addr == CSR_MSTATUS) || (addr == CSR_MTVEC) || (addr == CSR_MSCRATCH) ||
           (addr == CSR_MEPC) || (addr == CSR_MCAUSE) || (addr == CSR_MHARTID);
endfunction

task automatic model_reset();
    m_mstatus  = 32'd0;
    m_mtvec    = 32'd0;
    m_mscratch = 32'd0;
    m_mepc     = 32'd0;
    m_mcause   = 32'd0;
endtask

// runs one instruction in program order and returns what the unit should report
task automatic model_exec(input logic [31:0] ins, input logic [31:0] src_val,
                          input logic [31:0] pc_val, output logic [31:0] data,
                          output logic ill, output logic trap, output logic [31:0] vec);
    logic [2:0]  f3;
    logic [11:0] addr;
    logic [4:0]  src;
    logic [31:0] opnd;
    logic [31:0] old;
    logic [31:0] nxt;
    logic        wr;
    f3   = ins[14:12];
    addr = ins[31:20];
    src  = ins[19:15];
    data = 32'd0;
    ill  = 1'b0;
    trap = 1'b0;
    vec  = m_mtvec;  // mtvec is stored already aligned
    if (ins == ecall_instr()) begin
        trap     = 1'b1;
        m_mepc   = pc_val;
        m_mcause = CAUSE_ECALL_M;
    end else begin
        opnd = f3[2] ? {27'd0, src} : src_val;
        wr   = (f3[1:0] == 2'b01) || (src != 5'd0);  // set and clear with zero source only read
        case (addr)
            CSR_MSTATUS:  old = m_mstatus;
            CSR_MTVEC:    old = m_mtvec;
            CSR_MSCRATCH: old = m_mscratch;
            CSR_MEPC:     old = m_mepc;
            CSR_MCAUSE:   old = m_mcause;
            default:      old = 32'd0;  // mhartid and unknown addresses
        endcase
        case (f3[1:0])
            2'b01:   nxt = opnd;
            2'b10:   nxt = old | opnd;
            default: nxt = old & ~opnd;
        endcase
        if (!csr_known(addr) || (wr && (addr[11:10] == 2'b11))) begin
            ill = 1'b1;
        end else begin
            data = old;
            if (wr) begin
                case (addr)
                    CSR_MSTATUS:  m_mstatus  = nxt & MSTATUS_WMASK;
                    CSR_MTVEC:    m_mtvec    = {nxt[31:2], 2'b00};
                    CSR_MSCRATCH: m_mscratch = nxt;
                    CSR_MEPC:     m_mepc     = {nxt[31:2], 2'b00};
                    CSR_MCAUSE:   m_mcause   = nxt;
                    default: begin
                    end
                endcase
            end
        end
    end
endtask

`endif

//--- verif/tb_csr_unit.sv
`timescale 1ns/10ps

module tb_csr_unit
    import csr_pkg::*;
();

    localparam int RESET_CYCLES = 8;
    localparam int LATENCY      = 2;  // decode and writeback register stages
    localparam int N_RANDOM     = 300;
    localparam int N_B2B        = 48;
    localparam int N_ILLEGAL    = 60;
    localparam int N_ECALL      = 6;
    localparam int N_FLUSH      = 40;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + N_RANDOM + N_B2B + N_ILLEGAL + 4 * N_ECALL
                                  + N_FLUSH + 5 * 6 + 6 * (LATENCY + 4) + 40;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        instr_valid;
    logic [31:0] instr;
    logic [31:0] rs1_data;
    logic [31:0] pc;
    logic        flush;
    logic        rd_valid;
    logic [4:0]  rd_addr;
    logic [31:0] rd_data;
    logic        illegal;
    logic        trap_taken;
    logic [31:0] trap_vector;

    integer      seed = 87196;
    int          cycles = 0;
    int          errors = 0;
    int          checks = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          test_base = 0;
    logic [31:0] q_instr[$];  // instructions in flight, oldest first
    logic [31:0] q_rs1[$];
    logic [31:0] q_pc[$];
    int          q_cycle[$];

    `include "csr_model.svh"

    csr_unit dut (.*);

    initial begin
        forever #4 clk = ~clk;
    end

    always @(posedge clk) cycles <= cycles + 1;

    initial begin
        while (cycles <= CYCLE_LIMIT) begin
            @(posedge clk);
        end
        $display("error: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("STATUS: FAIL");
        $finish;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // stimulus and checking
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic step();
        logic [31:0] ins;
        logic [31:0] src_val;
        logic [31:0] pc_val;
        logic [31:0] exp_data;
        logic [31:0] exp_vec;
        logic        exp_ill;
        logic        exp_trap;
        @(posedge clk);
        #1;
        if (!rd_valid) begin
            check("illegal", 32'(illegal), 32'd0);
            check("trap_taken", 32'(trap_taken), 32'd0);
        end else if (q_instr.size() == 0) begin
            $display("error: rd_valid at cycle %0d with no instruction in flight", cycles);
            errors++;
        end else begin
            ins     = q_instr.pop_front();
            src_val = q_rs1.pop_front();
            pc_val  = q_pc.pop_front();
            check("latency", cycles - q_cycle.pop_front(), LATENCY);
            model_exec(ins, src_val, pc_val, exp_data, exp_ill, exp_trap, exp_vec);
            check("rd_addr", 32'(rd_addr), 32'(ins[11:7]));
            check("rd_data", rd_data, exp_data);
            check("illegal", 32'(illegal), 32'(exp_ill));
            check("trap_taken", 32'(trap_taken), 32'(exp_trap));
            if (exp_trap) check("trap_vector", trap_vector, exp_vec);
        end
    endtask

    task automatic issue(input logic [31:0] ins, input logic [31:0] src_val,
                         input logic [31:0] pc_val, input logic flush_in);
        instr_valid = 1'b1;
        instr       = ins;
        rs1_data    = src_val;
        pc          = pc_val;
        flush       = flush_in;
        if (!flush_in) begin  // a flushed instruction never reaches writeback
            q_instr.push_back(ins);
            q_rs1.push_back(src_val);
            q_pc.push_back(pc_val);
            q_cycle.push_back(cycles);
        end
        step();
    endtask

    task automatic idle();
        instr_valid = 1'b0;
        flush       = 1'b0;
        step();
    endtask

    task automatic issue_csr(input logic [2:0] f3, input logic [11:0] addr,
                             input logic [4:0] src, input logic flush_in);
        logic [31:0] r;
        logic [31:0] v;
        logic [31:0] p;
        r = $random(seed);
        v = $random(seed);
        p = $random(seed);
        issue(csr_instr(f3, addr, src, r[4:0]), v, {p[31:2], 2'b00}, flush_in);
    endtask

    function automatic logic [11:0] impl_addr(input logic [2:0] k);
        case (k)
            3'd0:    return CSR_MSTATUS;
            3'd1:    return CSR_MTVEC;
            3'd2:    return CSR_MSCRATCH;
            3'd3:    return CSR_MEPC;
            3'd4:    return CSR_MCAUSE;
            default: return CSR_MHARTID;
        endcase
    endfunction

    // 000 and 100 are not CSR ops so they fold onto the write forms
    function automatic logic [2:0] any_f3(input logic [2:0] r);
        return (r[1:0] == 2'b00) ? {r[2], 2'b01} : r;
    endfunction

    task automatic read_all();
        for (int k = 0; k < 6; k++) issue_csr(F3_CSRRS, impl_addr(3'(k)), 5'd0, 1'b0);
    endtask

    task automatic drain();
        while (q_instr.size() != 0) idle();
    endtask

    task automatic end_test(input string name);
        drain();
        tests_run++;
        if (errors == test_base) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: failed with %0d errors", name, errors - test_base);
            tests_failed++;
        end
        test_base = errors;
    endtask

    initial begin
        logic [31:0] r;
        logic [11:0] a;
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = 32'd0;
        rs1_data    = 32'd0;
        pc          = 32'd0;
        flush       = 1'b0;
        model_reset();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;

        check("rd_valid", 32'(rd_valid), 32'd0);
        check("illegal", 32'(illegal), 32'd0);
        check("trap_taken", 32'(trap_taken), 32'd0);
        read_all();
        end_test("reset_values");

        for (int i = 0; i < N_RANDOM; i++) begin
            r = $random(seed);
            if (r[5:4] == 2'b00) idle();
            else issue_csr(any_f3(r[2:0]), impl_addr(3'(r[31:11] % 6)), r[10:6], 1'b0);
        end
        end_test("random_ops");

        r = $random(seed);
        a = impl_addr(3'(r % 5));  // one writable CSR hammered without gaps
        for (int i = 0; i < N_B2B; i++) begin
            r = $random(seed);
            issue_csr(any_f3(r[2:0]), a, r[7:3], 1'b0);
        end
        end_test("back_to_back");

        for (int i = 0; i < N_ILLEGAL; i++) begin
            r = $random(seed);
            case (r[1:0])
                2'b00, 2'b01: issue_csr({r[2], 1'b1, r[3]}, impl_addr(3'(r[31:8] % 5)), 5'd0,
                                        1'b0);
                2'b10: issue_csr({r[2], 2'b01}, CSR_MHARTID, r[8:4], 1'b0);
                default: begin
                    a = r[31:20];
                    if (csr_known(a)) a[4] = ~a[4];
                    issue_csr(any_f3(r[2:0]), a, r[8:4], 1'b0);
                end
            endcase
        end
        read_all();
        end_test("zero_src_and_illegal");

        for (int i = 0; i < N_ECALL; i++) begin
            r = $random(seed);
            issue_csr(F3_CSRRW, CSR_MTVEC, r[4:0], 1'b0);
            issue(ecall_instr(), $random(seed), {r[31:2], 2'b00}, 1'b0);
            issue_csr(F3_CSRRS, CSR_MEPC, 5'd0, 1'b0);
            issue_csr(F3_CSRRS, CSR_MCAUSE, 5'd0, 1'b0);
        end
        end_test("ecall");

        for (int i = 0; i < N_FLUSH; i++) begin
            r = $random(seed);
            issue_csr(any_f3(r[2:0]), impl_addr(3'(r[31:11] % 6)), r[10:6], r[3]);
        end
        drain();
        repeat (3) idle();
        read_all();
        end_test("flush");

        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors",
                 tests_run, tests_failed, checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+verif
common/csr_pkg.sv
rtl/csr_decode.sv
csr_file/csr_file.sv
rtl/csr_writeback.sv
rtl/csr_unit.sv
verif/tb_csr_unit.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
    -f filelist.f --top-module tb_csr_unit --Mdir obj_dir -o sim_csr_unit

./obj_dir/sim_csr_unit | tee sim.log

if grep -q "^STATUS: PASS$" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed, see sim.log"
exit 1
